/* files.f */
+incdir+.
wormhole_pkg.sv
wormhole_link_if.sv
wormhole_two_fifo.sv
wormhole_adapter_in.sv
wormhole_adapter_out.sv
wormhole_router_adapter.sv
tb_wormhole_router_adapter.sv

/* Bender.yml */
package:
  name: wormhole_router_adapter

sources:
  - include_dirs:
      - .
    files:
      - wormhole_pkg.sv
      - wormhole_link_if.sv
      - wormhole_two_fifo.sv
      - wormhole_adapter_in.sv
      - wormhole_adapter_out.sv
      - wormhole_router_adapter.sv
  - target: test
    include_dirs:
      - .
    files:
      - tb_wormhole_router_adapter.sv

/* tb_wormhole_router_adapter.sv */
`include "wormhole_config.svh"

module tb_wormhole_router_adapter import wormhole_pkg::*; ();

  localparam logic [31:0] SEED = 32'h9227;
  localparam int NUM_PACKETS = 65;  // All packets sent over the run.
  localparam int CYCLES_PER_PACKET = 200;

  logic                      clk_i;
  logic                      reset_i;
  wh_packet_s                packet_i;
  logic                      v_i;
  logic                      ready_o;
  logic [`WH_LINK_WIDTH-1:0] link_data_i;
  logic                      link_v_i;
  logic                      link_ready_and_o;
  logic [`WH_LINK_WIDTH-1:0] link_data_o;
  logic                      link_v_o;
  logic                      link_ready_and_i;
  wh_packet_s                packet_o;
  logic                      v_o;
  logic                      yumi_i;

  logic [31:0] rng;
  logic [31:0] hold_rng;
  logic [31:0] stall_rng;
  logic        stall_en;
  logic        stall;
  int          errors;
  wh_packet_s  expected_q [$];

  wormhole_router_adapter dut0 (
    .clk_i           (clk_i),
    .reset_i         (reset_i),
    .packet_i        (packet_i),
    .v_i             (v_i),
    .ready_o         (ready_o),
    .link_data_i     (link_data_i),
    .link_v_i        (link_v_i),
    .link_ready_and_o(link_ready_and_o),
    .link_data_o     (link_data_o),
    .link_v_o        (link_v_o),
    .link_ready_and_i(link_ready_and_i),
    .packet_o        (packet_o),
    .v_o             (v_o),
    .yumi_i          (yumi_i)
  );

  // ==================================================
  // Clock, loopback gate, watchdog
  // ==================================================

  always #4 clk_i = ~clk_i;

  // A stall closes both ends of the loop in the same cycle.
  assign link_data_i      = link_data_o;
  assign link_v_i         = link_v_o & ~stall;
  assign link_ready_and_i = link_ready_and_o & ~stall;

  always @(posedge clk_i) begin
    #1;
    if (stall_en) begin
      stall_rng = xorshift(stall_rng);
      stall = (stall_rng[2:0] < 3'd3);  // Roughly 3 in 8.
    end else begin
      stall = 1'b0;
    end
  end

  initial begin
    repeat (NUM_PACKETS * CYCLES_PER_PACKET) @(posedge clk_i);
    $display("Timeout: the tests did not finish within %0d cycles.",
             NUM_PACKETS * CYCLES_PER_PACKET);
    $display("TEST FAIL");
    $finish;
  end

  // ==================================================
  // Helpers
  // ==================================================

  function automatic logic [31:0] xorshift(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  // Negative len draws one of 0, 1, 2.
  function automatic wh_packet_s make_packet(input int len);
    wh_packet_s p;
    logic [31:0] hi;
    rng = xorshift(rng);
    hi  = rng;
    rng = xorshift(rng);
    p.payload = {hi[`WH_MAX_PAYLOAD_WIDTH-33:0], rng}; // Upper bits dropped.
    p.cord    = rng[31:28];
    if (len < 0) begin
      rng = xorshift(rng);
      len = rng % 3;
    end
    p.len = len[`WH_LEN_WIDTH-1:0];
    return p;
  endfunction

  // Header carries 10 payload bits, each body flit 16 more.
  function automatic wh_packet_s truncate(input wh_packet_s p);
    int carried;
    int i;
    carried = `WH_HDR_PAYLOAD_WIDTH + `WH_LINK_WIDTH * p.len;
    for (i = 0; i < `WH_MAX_PAYLOAD_WIDTH; i++) begin
      if (i >= carried) p.payload[i] = 1'b0;
    end
    return p;
  endfunction

  task automatic offer_packet(input wh_packet_s p);
    logic fire;
    packet_i = p;
    v_i      = 1'b1;
    fire     = 1'b0;
    while (!fire) begin
      fire = ready_o;  // Stable until the edge.
      @(posedge clk_i);
      #1;
    end
  endtask

  task automatic send_packets(input int n, input int len);
    wh_packet_s p;
    int k;
    for (k = 0; k < n; k++) begin
      p = make_packet(len);
      offer_packet(p);
      expected_q.push_back(truncate(p));
    end
    v_i = 1'b0;
  endtask

  task automatic receive_packets(input int n, input int max_hold);
    wh_packet_s held;
    wh_packet_s exp;
    int hold;
    int k;
    for (k = 0; k < n; k++) begin
      while (v_o !== 1'b1) begin
        @(posedge clk_i);
        #1;
      end
      held = packet_o;
      if (expected_q.size() == 0) begin
        $display("Packet offered on v_o with no packet outstanding.");
        errors++;
        exp = held;
      end else begin
        exp = expected_q.pop_front();
      end
      if (held !== exp) begin
        $display("ERROR packet_o expected %h got %h", exp, held);
        errors++;
      end
      hold = 0;
      if (max_hold > 0) begin
        hold_rng = xorshift(hold_rng);
        hold = hold_rng % (max_hold + 1);
      end
      repeat (hold) begin
        @(posedge clk_i);
        #1;
        if (v_o !== 1'b1) begin
          $display("ERROR v_o expected %h got %h", 1'b1, v_o);
          errors++;
        end
        if (packet_o !== held) begin
          $display("ERROR packet_o expected %h got %h", held, packet_o);
          errors++;
        end
      end
      yumi_i = 1'b1;
      @(posedge clk_i);
      #1;
      yumi_i = 1'b0;
    end
  endtask

  // No late or repeated packet after a test.
  task automatic expect_drained();
    repeat (8) begin
      @(posedge clk_i);
      #1;
      if (v_o !== 1'b0) begin
        $display("ERROR v_o expected %h got %h", 1'b0, v_o);
        errors++;
      end
    end
    if (expected_q.size() != 0) begin
      $display("%0d sent packets never arrived.", expected_q.size());
      errors++;
      expected_q.delete();
    end
  endtask

  // ==================================================
  // Tests
  // ==================================================

  task automatic test_idle();
    repeat (10) begin
      @(posedge clk_i);
      #1;
      if (v_o !== 1'b0) begin
        $display("ERROR v_o expected %h got %h", 1'b0, v_o);
        errors++;
      end
      if (link_v_o !== 1'b0) begin
        $display("ERROR link_v_o expected %h got %h", 1'b0, link_v_o);
        errors++;
      end
    end
  endtask

  task automatic test_single_lengths();
    int len;
    for (len = 0; len < 3; len++) begin
      fork
        send_packets(1, len);
        receive_packets(1, 0);
      join
    end
    expect_drained();
  endtask

  task automatic run_stream(input int max_hold, input logic stalls);
    stall_en = stalls;
    fork
      send_packets(20, -1);
      receive_packets(20, max_hold);
    join
    stall_en = 1'b0;
    expect_drained();
  endtask

  task automatic test_reset_mid_packet();
    logic fire;
    offer_packet(make_packet(2));
    v_i  = 1'b0;
    fire = 1'b0;
    while (!fire) begin
      fire = link_v_o & link_ready_and_i;  // Header moves at this edge.
      @(posedge clk_i);
      #1;
    end
    reset_i = 1'b1;
    repeat (2) @(posedge clk_i);
    #1;
    reset_i = 1'b0;
    if (link_v_o !== 1'b0) begin
      $display("ERROR link_v_o expected %h got %h", 1'b0, link_v_o);
      errors++;
    end
    if (v_o !== 1'b0) begin
      $display("ERROR v_o expected %h got %h", 1'b0, v_o);
      errors++;
    end
    if (ready_o !== 1'b1) begin
      $display("ERROR ready_o expected %h got %h", 1'b1, ready_o);
      errors++;
    end
    // Empty buffer takes flits.
    if (link_ready_and_o !== 1'b1) begin
      $display("ERROR link_ready_and_o expected %h got %h", 1'b1, link_ready_and_o);
      errors++;
    end
    fork
      send_packets(1, 1);
      receive_packets(1, 0);
    join
    expect_drained();
  endtask

  initial begin
    clk_i     = 1'b0;
    reset_i   = 1'b1;
    packet_i  = '0;
    v_i       = 1'b0;
    yumi_i    = 1'b0;
    stall     = 1'b0;
    stall_en  = 1'b0;
    errors    = 0;
    rng       = SEED;
    hold_rng  = xorshift(xorshift(SEED));
    stall_rng = xorshift(SEED);
    repeat (2) @(posedge clk_i);
    #1;
    reset_i = 1'b0;

    test_idle();
    test_single_lengths();
    run_stream(0, 1'b0);  // Back-to-back.
    run_stream(6, 1'b0);  // Output back-pressure.
    run_stream(0, 1'b1);  // Link stalls.
    test_reset_mid_packet();

    $display("Errors: %0d", errors);
    if (errors == 0) begin
      $display("TEST PASS");
    end else begin
      $display("TEST FAIL");
    end
    $finish;
  end

endmodule

/* wormhole_router_adapter.sv */
`include "wormhole_config.svh"

module wormhole_router_adapter import wormhole_pkg::*; (
  input  logic                        clk_i,
  input  logic                        reset_i,

  input  logic [`WH_PACKET_WIDTH-1:0] packet_i,
  input  logic                        v_i,
  output logic                        ready_o,

  // From the router.
  input  logic [`WH_LINK_WIDTH-1:0]   link_data_i,
  input  logic                        link_v_i,
  output logic                        link_ready_and_o,

  // To the router.
  output logic [`WH_LINK_WIDTH-1:0]   link_data_o,
  output logic                        link_v_o,
  input  logic                        link_ready_and_i,

  output logic [`WH_PACKET_WIDTH-1:0] packet_o,
  output logic                        v_o,
  input  logic                        yumi_i
);

  wh_packet_s packet_li;
  wh_packet_s packet_lo;

  wormhole_link_if link_tx ();
  wormhole_link_if link_rx ();
  wormhole_link_if link_buf ();

  assign packet_li = wh_packet_s'(packet_i);
  assign packet_o  = packet_lo;

  // Plain link ports onto the interfaces.
  assign link_data_o       = link_tx.data;
  assign link_v_o          = link_tx.v;
  assign link_tx.ready_and = link_ready_and_i;
  assign link_rx.data      = wh_flit_u'(link_data_i);
  assign link_rx.v         = link_v_i;
  assign link_ready_and_o  = link_rx.ready_and;

  wormhole_adapter_in adapter_in (
    .clk_i   (clk_i),
    .reset_i (reset_i),
    .packet_i(packet_li),
    .v_i     (v_i),
    .ready_o (ready_o),
    .link_o  (link_tx.send)
  );

  wormhole_two_fifo rx_fifo (
    .clk_i  (clk_i),
    .reset_i(reset_i),
    .enq_i  (link_rx.receive),
    .deq_o  (link_buf.send)
  );

  wormhole_adapter_out adapter_out (
    .clk_i   (clk_i),
    .reset_i (reset_i),
    .link_i  (link_buf.receive),
    .packet_o(packet_lo),
    .v_o     (v_o),
    .yumi_i  (yumi_i)
  );

endmodule

/* wormhole_adapter_out.sv */
`include "wormhole_config.svh"

module wormhole_adapter_out import wormhole_pkg::*; (
  input  logic       clk_i,
  input  logic       reset_i,

  wormhole_link_if.receive link_i,

  output wh_packet_s packet_o,
  output logic       v_o,
  input  logic       yumi_i
);

  logic                     v_r;        // Whole packet held.
  logic                     body_st_r;  // Expecting body flits.
  logic [`WH_LEN_WIDTH-1:0] count_r;    // Body flits still to come.
  logic [`WH_LEN_WIDTH-1:0] idx_r;      // Body slot of the next flit.
  wh_packet_s               packet_r;
  wh_flit_u                 flit_li;
  logic                     link_fire;

  // ==================================================
  // Link side
  // ==================================================

  // Stall while a packet waits for yumi.
  assign link_i.ready_and = ~v_r;
  assign link_fire        = link_i.v & link_i.ready_and;
  assign flit_li          = link_i.data;

  // Assembly register.
  always_ff @(posedge clk_i) begin
    if (link_fire) begin
      if (!body_st_r) begin
        packet_r.payload <= '0;
        packet_r.payload[`WH_HDR_PAYLOAD_WIDTH-1:0] <= flit_li.hdr.hdr_payload;
        packet_r.len  <= flit_li.hdr.len;
        packet_r.cord <= flit_li.hdr.cord;
      end else begin
        packet_r.payload[`WH_HDR_PAYLOAD_WIDTH + idx_r*`WH_LINK_WIDTH +: `WH_LINK_WIDTH]
          <= flit_li.body;
      end
    end
  end

  // Control.
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      v_r       <= 1'b0;
      body_st_r <= 1'b0;
      count_r   <= '0;
      idx_r     <= '0;
    end else if (yumi_i) begin
      v_r <= 1'b0;
    end else if (link_fire) begin
      if (!body_st_r) begin
        count_r <= flit_li.hdr.len;
        idx_r   <= '0;
        if (flit_li.hdr.len == '0) begin
          v_r <= 1'b1;  // Header-only packet.
        end else begin
          body_st_r <= 1'b1;
        end
      end else begin
        count_r <= count_r - 1'b1;
        idx_r   <= idx_r + 1'b1;
        if (count_r == 'd1) begin
          v_r       <= 1'b1;
          body_st_r <= 1'b0;  // Back to header.
        end
      end
    end
  end

  // ==================================================
  // Packet side
  // ==================================================

  assign v_o      = v_r;
  assign packet_o = packet_r;

endmodule

/* wormhole_adapter_in.sv */
`include "wormhole_config.svh"

module wormhole_adapter_in import wormhole_pkg::*; (
  input  logic       clk_i,
  input  logic       reset_i,

  input  wh_packet_s packet_i,
  input  logic       v_i,
  output logic       ready_o,

  wormhole_link_if.send link_o
);

  localparam int BODY_WIDTH = `WH_MAX_PAYLOAD_WIDTH - `WH_HDR_PAYLOAD_WIDTH;

  logic                     busy_r;
  logic                     hdr_pending_r;  // Header not yet sent.
  logic [`WH_LEN_WIDTH-1:0] count_r;        // Flits left after the current one.
  wh_header_s               hdr_r;
  logic [BODY_WIDTH-1:0]    body_r;         // Remaining payload, low word next.
  wh_flit_u                 flit_lo;
  logic                     accept;
  logic                     link_fire;

  // ==================================================
  // Packet side
  // ==================================================

  assign ready_o = ~busy_r;
  assign accept  = v_i & ready_o;

  // ==================================================
  // Link side
  // ==================================================

  always_comb begin
    if (hdr_pending_r) begin
      flit_lo.hdr = hdr_r;
    end else begin
      flit_lo.body = body_r[`WH_LINK_WIDTH-1:0];
    end
  end

  assign link_o.data = flit_lo;
  assign link_o.v    = busy_r;
  assign link_fire   = link_o.v & link_o.ready_and;

  // Payload registers, loaded on accept and shifted per body flit.
  always_ff @(posedge clk_i) begin
    if (accept) begin
      hdr_r.hdr_payload <= packet_i.payload[`WH_HDR_PAYLOAD_WIDTH-1:0];
      hdr_r.len         <= packet_i.len;
      hdr_r.cord        <= packet_i.cord;
      body_r <= packet_i.payload[`WH_MAX_PAYLOAD_WIDTH-1:`WH_HDR_PAYLOAD_WIDTH];
    end else if (link_fire && !hdr_pending_r) begin
      body_r <= body_r >> `WH_LINK_WIDTH;
    end
  end

  // Control.
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      busy_r        <= 1'b0;
      hdr_pending_r <= 1'b0;
      count_r       <= '0;
    end else if (accept) begin
      busy_r        <= 1'b1;
      hdr_pending_r <= 1'b1;
      count_r       <= packet_i.len;
    end else if (link_fire) begin
      hdr_pending_r <= 1'b0;
      if (count_r == '0) begin
        busy_r <= 1'b0;  // Last flit gone.
      end else begin
        count_r <= count_r - 1'b1;
      end
    end
  end

endmodule

/* wormhole_two_fifo.sv */
module wormhole_two_fifo import wormhole_pkg::*; (
  input  logic     clk_i,
  input  logic     reset_i,
  wormhole_link_if.receive enq_i,
  wormhole_link_if.send    deq_o
);

  wh_flit_u mem [2];  // Flit slots.
  logic     wr_ptr_r;
  logic     rd_ptr_r;
  logic     full_r;
  logic     empty_r;
  logic     enq;
  logic     deq;

  assign enq_i.ready_and = ~full_r;
  assign deq_o.v         = ~empty_r;
  assign deq_o.data      = mem[rd_ptr_r];  // Oldest entry.

  assign enq = enq_i.v & enq_i.ready_and;
  assign deq = deq_o.v & deq_o.ready_and;

  always_ff @(posedge clk_i) begin
    if (enq) begin
      mem[wr_ptr_r] <= enq_i.data;
    end
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      wr_ptr_r <= 1'b0;
      rd_ptr_r <= 1'b0;
      full_r   <= 1'b0;
      empty_r  <= 1'b1;
    end else begin
      if (enq) wr_ptr_r <= ~wr_ptr_r;
      if (deq) rd_ptr_r <= ~rd_ptr_r;
      if (enq && !deq) begin
        empty_r <= 1'b0;
        full_r  <= (~wr_ptr_r == rd_ptr_r);  // Second slot taken.
      end else if (deq && !enq) begin
        full_r  <= 1'b0;
        empty_r <= (~rd_ptr_r == wr_ptr_r);
      end
    end
  end

endmodule

/* wormhole_link_if.sv */
`include "wormhole_config.svh"

// Ready-and flit link.
// A flit moves on a clock edge with v and ready_and both high.
interface wormhole_link_if import wormhole_pkg::*; ();

  wh_flit_u data;
  logic     v;
  logic     ready_and;

  // Flit source.
  modport send (
    output data,
    output v,
    input  ready_and
  );

  // Flit sink.
  modport receive (
    input  data,
    input  v,
    output ready_and
  );

endinterface

/* wormhole_pkg.sv */
`include "wormhole_config.svh"

package wormhole_pkg;

  // Whole packet, cord in the low bits.
  typedef struct packed {
    logic [`WH_MAX_PAYLOAD_WIDTH-1:0] payload;
    logic [`WH_LEN_WIDTH-1:0]         len;
    logic [`WH_CORD_WIDTH-1:0]        cord;
  } wh_packet_s;

  // Header flit, same field order as the packet low bits.
  typedef struct packed {
    logic [`WH_HDR_PAYLOAD_WIDTH-1:0] hdr_payload;
    logic [`WH_LEN_WIDTH-1:0]         len;
    logic [`WH_CORD_WIDTH-1:0]        cord;
  } wh_header_s;

  // One link word.
  // Read as a header at packet start, as raw payload after that.
  typedef union packed {
    wh_header_s                hdr;
    logic [`WH_LINK_WIDTH-1:0] body;
  } wh_flit_u;

endpackage

/* wormhole_config.svh */
`ifndef WORMHOLE_CONFIG_SVH
`define WORMHOLE_CONFIG_SVH

// ==================================================
// Link and packet widths
// ==================================================

`define WH_LINK_WIDTH        16
`define WH_CORD_WIDTH        4
`define WH_LEN_WIDTH         2  // Body flits per packet.
`define WH_MAX_PAYLOAD_WIDTH 42

// Packet is {payload, len, cord}.
`define WH_PACKET_WIDTH \
  (`WH_MAX_PAYLOAD_WIDTH + `WH_LEN_WIDTH + `WH_CORD_WIDTH)

// Payload room left in the header flit.
`define WH_HDR_PAYLOAD_WIDTH \
  (`WH_LINK_WIDTH - `WH_LEN_WIDTH - `WH_CORD_WIDTH)

`endif
